//--- src.f
verilog/sm83_pkg.sv
verilog/sm83_tstate.sv
verilog/sm83_io.sv
verilog/sm83_mcycle_ctl.sv
verilog/sm83_bus_unit.sv
test/clock_gen.sv
test/ext_mem_model.sv
test/sm83_bus_unit_tb.sv

//--- Makefile
# Verilator build and run for the SM83 bus unit testbench.

VERILATOR ?= verilator
TOP       ?= sm83_bus_unit_tb
SRC_LIST  ?= src.f
BUILD_DIR ?= build
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(SRC_LIST)

# The simulator exits with a failing status when the testbench stops on an error.
run: compile
	$(SIM)

clean:
	rm -rf $(BUILD_DIR)

//--- test/sm83_bus_unit_tb.sv
`timescale 1ns/10ps

module sm83_bus_unit_tb;

	localparam int RESET_CYCLES = 10;
	// Where the expected response byte of a row comes from.
	localparam logic [1:0] EXP_NONE  = 2'd0;
	localparam logic [1:0] EXP_LIT   = 2'd1;
	localparam logic [1:0] EXP_MODEL = 2'd2;

	typedef struct packed {
		sm83_pkg::req_kind_t kind;
		sm83_pkg::addr_t     addr;
		sm83_pkg::word_t     wdata;
		logic                cb;
		logic [1:0]          stall;
		logic [1:0]          src;
		sm83_pkg::word_t     exp_data;
	} row_t;

	logic                clk;
	logic                reset;
	logic                req_valid;
	sm83_pkg::req_kind_t req_kind;
	sm83_pkg::addr_t     req_addr;
	sm83_pkg::word_t     req_wdata;
	logic                req_cb;
	logic                req_ready;
	logic                rsp_valid;
	sm83_pkg::word_t     rsp_data;
	sm83_pkg::word_t     rsp_opcode;
	logic                rsp_bank_cb;
	logic                rsp_ready;
	sm83_pkg::addr_t     addr;
	logic                rd;
	logic                wr;
	sm83_pkg::word_t     ext_dout;
	sm83_pkg::word_t     ext_din;

	// Reference state kept alongside the DUT.
	row_t            rows[$];
	sm83_pkg::word_t shadow [0:65535];
	sm83_pkg::word_t shadow_ie;
	sm83_pkg::word_t ir;
	logic            bank;
	int              seed;
	int              cycles = 0;
	int              limit = 0;

	clock_gen #(.HALF_PERIOD(50), .RESET_CYCLES(RESET_CYCLES)) clock_gen_i (.clk, .reset);

	sm83_bus_unit sm83_bus_unit_i (.*);

	ext_mem_model ext_mem_model_i (
		.clk,
		.addr,
		.rd,
		.wr,
		.wdata(ext_dout),
		.rdata(ext_din)
	);

	task automatic check_value(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		if (actual !== expected) begin
			$display("MISMATCH %s: got %h, expected %h", name, actual, expected);
			$display("Test failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// Opcodes the core never decodes.
	function automatic logic is_illegal_opcode(input sm83_pkg::word_t b);
		case (b)
			8'hd3, 8'hdb, 8'hdd, 8'he3, 8'he4, 8'heb: return 1'b1;
			8'hec, 8'hed, 8'hf4, 8'hfc, 8'hfd: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	task automatic add_row(input sm83_pkg::req_kind_t kind, input sm83_pkg::addr_t a,
		input sm83_pkg::word_t wd, input logic cb, input logic [1:0] stall,
		input logic [1:0] src, input sm83_pkg::word_t exp_data);
		row_t r;
		r.kind     = kind;
		r.addr     = a;
		r.wdata    = wd;
		r.cb       = cb;
		r.stall    = stall;
		r.src      = src;
		r.exp_data = exp_data;
		rows.push_back(r);
	endtask

	task automatic run_row(input row_t r);
		sm83_pkg::word_t want;
		int lat;
		int rd_n;
		int wr_n;
		int exp_lat;
		int exp_rd;
		int exp_wr;
		want = r.exp_data;
		if (r.src == EXP_MODEL)
			want = (r.kind == sm83_pkg::REQ_READ && r.addr == sm83_pkg::IE_ADDR) ?
				shadow_ie : shadow[r.addr];
		exp_lat = (r.kind == sm83_pkg::REQ_FETCH_ZERO) ? 1 : 5;
		exp_rd = (r.kind == sm83_pkg::REQ_READ || r.kind == sm83_pkg::REQ_FETCH) ? 4 : 0;
		exp_wr = (r.kind == sm83_pkg::REQ_WRITE && r.addr != sm83_pkg::IE_ADDR) ? 4 : 0;
		// Reference state as it stands once this request completes.
		case (r.kind)
			sm83_pkg::REQ_WRITE: begin
				if (r.addr == sm83_pkg::IE_ADDR)
					shadow_ie = r.wdata;
				else
					shadow[r.addr] = r.wdata;
			end
			sm83_pkg::REQ_FETCH: begin
				ir   = want;
				bank = r.cb;
			end
			sm83_pkg::REQ_FETCH_ZERO: begin
				ir   = 8'h00;
				bank = r.cb;
			end
			default: ;
		endcase
		@(posedge clk);
		req_valid <= 1'b1;
		req_kind  <= r.kind;
		req_addr  <= r.addr;
		req_wdata <= r.wdata;
		req_cb    <= r.cb;
		rsp_ready <= (r.stall == 2'd0);
		do
			@(negedge clk);
		while (!req_ready);
		@(posedge clk);
		req_valid <= 1'b0;
		lat  = 0;
		rd_n = 0;
		wr_n = 0;
		do begin
			@(negedge clk);
			lat++;
			if (rd)
				rd_n++;
			if (wr)
				wr_n++;
			if (rd || wr)
				check_value("addr", addr, r.addr);
			if (wr)
				check_value("ext_dout", 16'(ext_dout), 16'(r.wdata));
		end while (!rsp_valid);
		check_value("latency", 16'(lat), 16'(exp_lat));
		check_value("rd_cycles", 16'(rd_n), 16'(exp_rd));
		check_value("wr_cycles", 16'(wr_n), 16'(exp_wr));
		// A waiting response holds still and blocks new requests.
		for (int s = 0; s <= int'(r.stall); s++) begin
			if (s > 0)
				@(negedge clk);
			check_value("rsp_valid", 16'(rsp_valid), 16'h0001);
			check_value("req_ready", 16'(req_ready), 16'h0000);
			if (r.src != EXP_NONE)
				check_value("rsp_data", 16'(rsp_data), 16'(want));
			check_value("rsp_opcode", 16'(rsp_opcode), 16'(ir));
			check_value("rsp_bank_cb", 16'(rsp_bank_cb), 16'(bank));
		end
		if (r.stall != 2'd0) begin
			@(posedge clk);
			rsp_ready <= 1'b1;
		end
	endtask

	// The bus never reads and writes at once.
	always @(negedge clk) begin
		if (!reset)
			check_value("rd_and_wr", 16'(rd && wr), 16'h0000);
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("Timeout: the run did not finish within %0d cycles", limit);
			$display("Test failed");
			$fatal(1, "cycle limit reached");
		end
	end

	initial begin
		sm83_pkg::word_t b;
		req_valid = 1'b0;
		req_kind  = sm83_pkg::REQ_READ;
		req_addr  = 16'h0000;
		req_wdata = 8'h00;
		req_cb    = 1'b0;
		rsp_ready = 1'b0;
		shadow_ie = 8'h00;
		ir        = 8'h00;
		bank      = 1'b0;
		seed      = 32'h9fc2;
		for (int a = 0; a < 65536; a++) begin
			b = 8'($random(seed));
			if (is_illegal_opcode(b))
				b = 8'h00;
			shadow[16'(a)] = b;
			ext_mem_model_i.mem[16'(a)] = b;
		end
		// kind, address, write data, cb, stall cycles, expected source, expected byte
		add_row(sm83_pkg::REQ_READ, 16'h0000, 8'h00, 1'b0, 2'd0, EXP_MODEL, 8'h00);
		add_row(sm83_pkg::REQ_FETCH, 16'h0100, 8'h00, 1'b0, 2'd0, EXP_MODEL, 8'h00);
		add_row(sm83_pkg::REQ_READ, 16'hc123, 8'h00, 1'b0, 2'd2, EXP_MODEL, 8'h00);
		add_row(sm83_pkg::REQ_WRITE, 16'hc000, 8'h5a, 1'b0, 2'd0, EXP_NONE, 8'h00);
		add_row(sm83_pkg::REQ_READ, 16'hc000, 8'h00, 1'b0, 2'd0, EXP_LIT, 8'h5a);
		add_row(sm83_pkg::REQ_WRITE, 16'hffff, 8'h1f, 1'b0, 2'd0, EXP_NONE, 8'h00);
		add_row(sm83_pkg::REQ_READ, 16'hffff, 8'h00, 1'b0, 2'd0, EXP_LIT, 8'h1f);
		add_row(sm83_pkg::REQ_FETCH, 16'h0150, 8'h00, 1'b1, 2'd1, EXP_MODEL, 8'h00);
		add_row(sm83_pkg::REQ_FETCH_ZERO, 16'h0000, 8'h00, 1'b0, 2'd0, EXP_LIT, 8'h00);
		add_row(sm83_pkg::REQ_FETCH_ZERO, 16'h0000, 8'h00, 1'b1, 2'd3, EXP_LIT, 8'h00);
		add_row(sm83_pkg::REQ_READ, 16'h2345, 8'h00, 1'b0, 2'd0, EXP_MODEL, 8'h00);
		add_row(sm83_pkg::REQ_WRITE, 16'h8000, 8'ha5, 1'b0, 2'd2, EXP_NONE, 8'h00);
		add_row(sm83_pkg::REQ_READ, 16'h8000, 8'h00, 1'b0, 2'd0, EXP_LIT, 8'ha5);
		add_row(sm83_pkg::REQ_WRITE, 16'hffff, 8'h00, 1'b0, 2'd0, EXP_NONE, 8'h00);
		add_row(sm83_pkg::REQ_READ, 16'hffff, 8'h00, 1'b0, 2'd0, EXP_MODEL, 8'h00);
		add_row(sm83_pkg::REQ_WRITE, 16'hfffe, 8'h3c, 1'b0, 2'd0, EXP_NONE, 8'h00);
		add_row(sm83_pkg::REQ_READ, 16'hfffe, 8'h00, 1'b0, 2'd0, EXP_LIT, 8'h3c);
		add_row(sm83_pkg::REQ_READ, 16'hffff, 8'h00, 1'b0, 2'd0, EXP_LIT, 8'h00);
		add_row(sm83_pkg::REQ_FETCH, 16'h4000, 8'h00, 1'b0, 2'd0, EXP_MODEL, 8'h00);
		add_row(sm83_pkg::REQ_READ, 16'h00ff, 8'h00, 1'b0, 2'd0, EXP_MODEL, 8'h00);
		add_row(sm83_pkg::REQ_WRITE, 16'h1234, 8'hc3, 1'b0, 2'd1, EXP_NONE, 8'h00);
		add_row(sm83_pkg::REQ_FETCH, 16'h1234, 8'h00, 1'b1, 2'd0, EXP_LIT, 8'hc3);
		add_row(sm83_pkg::REQ_READ, 16'h7fff, 8'h00, 1'b0, 2'd2, EXP_MODEL, 8'h00);
		add_row(sm83_pkg::REQ_WRITE, 16'hffff, 8'he1, 1'b0, 2'd0, EXP_NONE, 8'h00);
		add_row(sm83_pkg::REQ_READ, 16'hffff, 8'h00, 1'b0, 2'd0, EXP_LIT, 8'he1);
		add_row(sm83_pkg::REQ_FETCH_ZERO, 16'h0000, 8'h00, 1'b0, 2'd0, EXP_LIT, 8'h00);
		limit = 12 * rows.size() + RESET_CYCLES;
		do
			@(negedge clk);
		while (reset);
		foreach (rows[i])
			run_row(rows[i]);
		@(posedge clk);
		$display("Test completed successfully");
		$finish;
	end

endmodule

//--- test/ext_mem_model.sv
`timescale 1ns/10ps

module ext_mem_model (
	input  logic            clk,
	input  sm83_pkg::addr_t addr,
	input  logic            rd,
	input  logic            wr,
	input  sm83_pkg::word_t wdata,
	output sm83_pkg::word_t rdata
);

	// Image is loaded by the testbench at time zero.
	sm83_pkg::word_t mem [0:65535];

	// An idle bus floats high.
	assign rdata = rd ? mem[addr] : 8'hff;

	always @(posedge clk) begin
		if (wr)
			mem[addr] = wdata;
	end

endmodule

//--- test/clock_gen.sv
`timescale 1ns/10ps

module clock_gen #(
	parameter int HALF_PERIOD  = 50,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// Reset drops on a rising edge once the count is reached.
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

//--- verilog/sm83_bus_unit.sv
`timescale 1ns/10ps

module sm83_bus_unit (
	input  logic                clk,
	input  logic                reset,
	input  logic                req_valid,
	input  sm83_pkg::req_kind_t req_kind,
	input  sm83_pkg::addr_t     req_addr,
	input  sm83_pkg::word_t     req_wdata,
	input  logic                req_cb,
	output logic                req_ready,
	output logic                rsp_valid,
	output sm83_pkg::word_t     rsp_data,
	output sm83_pkg::word_t     rsp_opcode,
	output logic                rsp_bank_cb,
	input  logic                rsp_ready,
	output sm83_pkg::addr_t     addr,
	output logic                rd,
	output logic                wr,
	output sm83_pkg::word_t     ext_dout,
	input  sm83_pkg::word_t     ext_din
);

	// T-states.
	logic t1;
	logic t2;
	logic t3;
	logic t4;

	// Controller to io strobes.
	logic            mread;
	logic            mwrite;
	logic            apin_we;
	logic            dl_we;
	logic            ctl_ir_we;
	logic            ctl_ir_bank_we;
	logic            ctl_ir_bank_cb_set;
	logic            ctl_zero_data_oe;
	logic            iena_sel;
	sm83_pkg::addr_t ain;
	sm83_pkg::word_t din;
	sm83_pkg::word_t iena;

	// io back to controller.
	sm83_pkg::word_t dout;
	sm83_pkg::word_t opcode;

	sm83_tstate sm83_tstate_i (.*);

	sm83_mcycle_ctl sm83_mcycle_ctl_i (.*);

	// Address pins come out of the io block as aout.
	sm83_io sm83_io_i (
		.*,
		.aout(addr),
		.bank_cb()
	);

endmodule

//--- verilog/sm83_mcycle_ctl.sv
`timescale 1ns/10ps

module sm83_mcycle_ctl (
	input  logic                clk,
	input  logic                reset,
	input  logic                t4,
	input  logic                req_valid,
	input  logic                req_cb,
	input  logic                rsp_ready,
	input  logic                rd,
	input  sm83_pkg::req_kind_t req_kind,
	input  sm83_pkg::addr_t     req_addr,
	input  sm83_pkg::word_t     req_wdata,
	input  sm83_pkg::word_t     dout,
	input  sm83_pkg::word_t     opcode,
	output logic                req_ready,
	output logic                rsp_valid,
	output logic                mread,
	output logic                mwrite,
	output logic                apin_we,
	output logic                dl_we,
	output logic                ctl_ir_we,
	output logic                ctl_ir_bank_we,
	output logic                ctl_ir_bank_cb_set,
	output logic                ctl_zero_data_oe,
	output logic                iena_sel,
	output sm83_pkg::addr_t     ain,
	output sm83_pkg::word_t     din,
	output sm83_pkg::word_t     iena,
	output sm83_pkg::word_t     rsp_data,
	output sm83_pkg::word_t     rsp_opcode,
	output logic                rsp_bank_cb
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BUSY,
		ST_PENDING
	} state_t;

	state_t              state;
	sm83_pkg::req_kind_t kind_r;
	logic                cb_r;
	logic                ie_sel_r;
	sm83_pkg::word_t     ie_r;
	logic                accept;
	logic                ie_hit;
	logic                zero_fetch;
	logic                cycle_end;
	logic                fetch_end;

	// New work is taken only at a cycle boundary with nothing in flight.
	assign req_ready  = (state == ST_IDLE) && t4;
	assign rsp_valid  = (state == ST_PENDING);
	assign accept     = req_valid && req_ready;
	assign ie_hit     = (req_addr == sm83_pkg::IE_ADDR);
	assign zero_fetch = accept && (req_kind == sm83_pkg::REQ_FETCH_ZERO);
	assign cycle_end  = (state == ST_BUSY) && t4;
	assign fetch_end  = cycle_end && rd && (kind_r == sm83_pkg::REQ_FETCH);

	// Bus strobes all come in the accepting t4.
	assign mread   = accept && (req_kind == sm83_pkg::REQ_READ ||
		req_kind == sm83_pkg::REQ_FETCH);
	// IE writes stay on chip.
	assign mwrite  = accept && (req_kind == sm83_pkg::REQ_WRITE) && !ie_hit;
	assign apin_we = accept && (req_kind != sm83_pkg::REQ_FETCH_ZERO);
	assign dl_we   = accept && (req_kind == sm83_pkg::REQ_WRITE);
	assign ain     = req_addr;
	assign din     = req_wdata;

	// IR loads at the fetch's last t4, or right away for a zero fetch.
	assign ctl_ir_we          = fetch_end || zero_fetch;
	assign ctl_ir_bank_we     = fetch_end || zero_fetch;
	assign ctl_ir_bank_cb_set = zero_fetch ? req_cb : cb_r;
	assign ctl_zero_data_oe   = zero_fetch;

	assign iena     = ie_r;
	assign iena_sel = (state == ST_BUSY) && ie_sel_r;

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= ST_IDLE;
			ie_r        <= '0;
			rsp_bank_cb <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (accept)
						state <= zero_fetch ? ST_PENDING : ST_BUSY;
				end
				ST_BUSY: begin
					if (t4)
						state <= ST_PENDING;
				end
				ST_PENDING: begin
					if (rsp_ready)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
			if (accept && req_kind == sm83_pkg::REQ_WRITE && ie_hit)
				ie_r <= req_wdata;
			// Mirrors the bank flag held in the io block.
			if (ctl_ir_bank_we)
				rsp_bank_cb <= ctl_ir_bank_cb_set;
		end
	end

	// Request fields kept for the rest of the machine cycle.
	always_ff @(posedge clk) begin
		if (accept) begin
			kind_r   <= req_kind;
			cb_r     <= req_cb;
			ie_sel_r <= (req_kind == sm83_pkg::REQ_READ) && ie_hit;
		end
	end

	// Response hold registers.
	always_ff @(posedge clk) begin
		if (zero_fetch || cycle_end) begin
			rsp_data   <= zero_fetch ? '0 : dout;
			rsp_opcode <= opcode;
		end
	end

	// A waiting request holds its fields until it is taken.
	assert property (@(posedge clk) disable iff (reset)
		(req_valid && !req_ready) |=> (req_valid && $stable(req_kind) &&
			$stable(req_addr) && $stable(req_wdata) && $stable(req_cb)))
		else $error("request changed while waiting for req_ready");

endmodule

//--- verilog/sm83_io.sv
`timescale 1ns/10ps

module sm83_io (
	input  logic            clk,
	input  logic            reset,
	input  logic            t1,
	input  logic            t2,
	input  logic            t3,
	input  logic            t4,
	input  logic            mread,
	input  logic            mwrite,
	input  logic            apin_we,
	input  logic            dl_we,
	input  logic            iena_sel,
	input  logic            ctl_ir_we,
	input  logic            ctl_ir_bank_we,
	input  logic            ctl_ir_bank_cb_set,
	input  logic            ctl_zero_data_oe,
	input  sm83_pkg::addr_t ain,
	input  sm83_pkg::word_t din,
	input  sm83_pkg::word_t ext_din,
	input  sm83_pkg::word_t iena,
	output sm83_pkg::addr_t aout,
	output sm83_pkg::word_t dout,
	output sm83_pkg::word_t ext_dout,
	output sm83_pkg::word_t opcode,
	output logic            rd,
	output logic            wr,
	output logic            bank_cb
);

	sm83_pkg::word_t data;
	sm83_pkg::word_t bus_byte;
	sm83_pkg::word_t data_t4;
	sm83_pkg::word_t opcode_r;

	// A strobe seen at t4 opens the next machine cycle, and rd or wr stays up through it.
	always_ff @(posedge clk) begin
		if (reset) begin
			rd <= 1'b0;
			wr <= 1'b0;
		end else if (t4) begin
			rd <= mread;
			wr <= mwrite;
		end
	end

	// Upper address lines drop to zero between cycles, a new address overrides.
	always_ff @(posedge clk) begin
		if (t4)
			aout[sm83_pkg::ADDR_W-1:sm83_pkg::DATA_W] <= '0;
		if (apin_we)
			aout <= ain;
	end

	// Byte arriving at the end of a read.
	assign bus_byte = iena_sel ? iena : ext_din;
	assign data_t4  = ctl_zero_data_oe ? '0 : bus_byte;

	// Data latch.
	always_ff @(posedge clk) begin
		if (ctl_zero_data_oe)
			data <= '0;
		else if (dl_we)
			data <= din;
		else if (rd && t4)
			data <= bus_byte;
	end

	// During the read's t4 the incoming byte is passed straight through.
	assign dout     = (rd && t4) ? data_t4 : data;
	assign ext_dout = data;

	// Instruction register and CB bank flag.
	always_ff @(posedge clk) begin
		if (reset) begin
			opcode_r <= '0;
			bank_cb  <= 1'b0;
		end else begin
			if (ctl_ir_we)
				opcode_r <= data_t4;
			if (ctl_ir_bank_we)
				bank_cb <= ctl_ir_bank_cb_set;
		end
	end

	// The opcode being loaded is visible in the same cycle.
	assign opcode = ctl_ir_we ? data_t4 : opcode_r;

	// A bus cycle may only be started at the end of the previous one.
	assert property (@(posedge clk) disable iff (reset) (mread || mwrite) |-> t4)
		else $error("mread or mwrite outside t4");

	// Only one kind of cycle at a time.
	assert property (@(posedge clk) disable iff (reset) !(mread && mwrite))
		else $error("mread and mwrite together");

	// The IR is loaded from a finishing read, or forced to zero.
	assert property (@(posedge clk) disable iff (reset)
		ctl_ir_we |-> ((t4 && rd) || ctl_zero_data_oe))
		else $error("instruction register written outside a read t4");

	// Address and data latches are never loaded in the middle of a machine cycle.
	assert property (@(posedge clk) disable iff (reset)
		(t1 || t2 || t3) |-> !(apin_we || dl_we || ctl_ir_bank_we))
		else $error("latch enable in t1 to t3");

endmodule

//--- verilog/sm83_tstate.sv
`timescale 1ns/10ps

module sm83_tstate (
	input  logic clk,
	input  logic reset,
	output logic t1,
	output logic t2,
	output logic t3,
	output logic t4
);

	// One-hot ring, bit 0 is t1 and bit 3 is t4.
	logic [3:0] ring;

	// Reset parks the ring on t4 so the first machine cycle can start at once.
	always_ff @(posedge clk) begin
		if (reset)
			ring <= 4'b1000;
		else
			ring <= {ring[2:0], ring[3]};
	end

	assign t1 = ring[0];
	assign t2 = ring[1];
	assign t3 = ring[2];
	assign t4 = ring[3];

	// Both other blocks key their strobes on a single active T-state.
	assert property (@(posedge clk) disable iff (reset) $onehot(ring))
		else $error("T-state ring is not one-hot: %b", ring);

endmodule

//--- verilog/sm83_pkg.sv
package sm83_pkg;

	// External bus widths.
	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	typedef logic [DATA_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;

	// Kinds of memory cycle the core side can ask for.
	typedef enum logic [1:0] {
		REQ_READ       = 2'd0,
		REQ_WRITE      = 2'd1,
		REQ_FETCH      = 2'd2,
		// Loads 00 into the instruction register, used on interrupt dispatch.
		REQ_FETCH_ZERO = 2'd3
	} req_kind_t;

	// Interrupt-enable register, served on chip.
	localparam addr_t IE_ADDR = 16'hffff;

endpackage
